//--- include/mouse_cfg.svh
/*
 * Fixed widths and depths of the trackball interface.
 * Include this wherever the counter width, the synchronizer depth or the
 * read bus width is needed. The package pulls it in for its typedefs.
 */

`ifndef MOUSE_CFG_SVH
`define MOUSE_CFG_SVH

// position counter width, the counts wrap at this size
`define MOUSE_CNT_W 12

// number of flops between an external pin and the clk domain
`define MOUSE_SYNC_STAGES 2

// width of the cpu read bus
`define MOUSE_BYTE_W 8

`endif

//--- verilog/mouse_pkg.sv
/*
 * Shared types of the trackball interface.
 * Modules take them by a wildcard import in their header.
 */

`include "mouse_cfg.svh"

package mouse_pkg;

    // one axis position, an up/down count that wraps
    typedef logic [`MOUSE_CNT_W-1:0] count_t;

    // a quadrature pair with phase A in bit 0 and phase B in bit 1
    typedef logic [1:0] quad_t;

    // one byte as seen on the cpu read bus
    typedef logic [`MOUSE_BYTE_W-1:0] bus_byte_t;

    // the read bus carries the full count split over two bytes
    // upper byte holds four status bits and the high nibble
    // lower byte holds the low eight bits of the count

endpackage

//--- verilog/mouse_input_sync.sv
/*
 * Input synchronizers for the trackball pins.
 * Quadrature pairs, buttons and axis clear pins are asynchronous to clk
 * and each goes through its own chain of flops before use.
 */

`include "mouse_cfg.svh"

module mouse_input_sync
    import mouse_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  quad_t x_in,
    input  quad_t y_in,
    input  logic  rightn,
    input  logic  leftn,
    input  logic  middlen,
    input  logic  x_rstn,
    input  logic  y_rstn,
    output quad_t x_q,
    output quad_t y_q,
    output logic  right_q,
    output logic  left_q,
    output logic  middle_q,
    output logic  x_clr_n,
    output logic  y_clr_n
);

    logic [8:0] pins;                                   // all asynchronous pins side by side
    logic [8:0] sync_r [`MOUSE_SYNC_STAGES];            // one row per synchronizer stage

    // quadrature bits sit low so they can reset to 0 while the rest reset high
    assign pins = {x_rstn, y_rstn, middlen, leftn, rightn, y_in, x_in};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MOUSE_SYNC_STAGES; i++) begin
                sync_r[i] <= 9'b1_1111_0000;            // buttons and clears inactive, pairs at 0
            end
        end else begin
            sync_r[0] <= pins;                          // first stage may go metastable
            for (int i = 1; i < `MOUSE_SYNC_STAGES; i++) begin
                sync_r[i] <= sync_r[i-1];               // later stages settle the value
            end
        end
    end

    // the last stage feeds the rest of the design
    assign x_q      = sync_r[`MOUSE_SYNC_STAGES-1][1:0];
    assign y_q      = sync_r[`MOUSE_SYNC_STAGES-1][3:2];
    assign right_q  = sync_r[`MOUSE_SYNC_STAGES-1][4];
    assign left_q   = sync_r[`MOUSE_SYNC_STAGES-1][5];
    assign middle_q = sync_r[`MOUSE_SYNC_STAGES-1][6];
    assign y_clr_n  = sync_r[`MOUSE_SYNC_STAGES-1][7];
    assign x_clr_n  = sync_r[`MOUSE_SYNC_STAGES-1][8];

endmodule

//--- verilog/mouse_axis.sv
/*
 * Quadrature decoder and position counter for one trackball axis.
 * Takes an already synchronized pair and gives a wrapping count and a
 * sticky active-low flag that is set by motion and cleared by a read.
 */

module mouse_axis
    import mouse_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  quad_t  sig,                                 // synchronized quadrature pair
    input  logic   clr_n,                               // synchronous axis clear, active low
    input  logic   flag_clr_n,                          // chip select, a low cycle clears the flag
    output logic   flagn,                               // low after motion until the next read
    output count_t count
);

    quad_t prev_sig;                                    // pair as seen on the previous cycle
    quad_t sig_chg;                                     // bits of the pair that just toggled
    logic  [1:0] hist;                                  // did phase A move, for the last two edges
    logic  dir;                                         // set means count down
    logic  any_chg;
    logic  step;
    logic  rise_a;
    logic  fall_a;
    logic  new_dir;

    assign sig_chg = sig ^ prev_sig;
    assign any_chg = |sig_chg;

    // alternating channels in the history means the motion is steady
    // and the stored direction can be trusted for this edge
    assign step = any_chg && (hist[0] != hist[1]);

    assign rise_a = sig[0] & ~prev_sig[0];
    assign fall_a = ~sig[0] & prev_sig[0];

    // B already high when A rises, or low when A falls, means B leads A
    assign new_dir = (rise_a & sig[1]) | (fall_a & ~sig[1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_sig <= '0;
            hist     <= 2'b00;
            dir      <= 1'b0;
            count    <= '0;
            flagn    <= 1'b1;
        end else if (!clr_n) begin
            prev_sig <= sig;                            // keep tracking so release gives no false edge
            hist     <= 2'b00;
            dir      <= 1'b0;
            count    <= '0;
            flagn    <= 1'b1;
        end else begin
            prev_sig <= sig;

            if (any_chg) begin
                if (step) begin
                    count <= dir ? count - 1'b1 : count + 1'b1; // wraps at the counter width
                end else begin
                    dir <= new_dir;                     // after a clear or a reversal, relearn
                end
                hist <= {hist[0], sig_chg[0]};          // shift in whether A moved this time
            end

            // a count in the same cycle as a read keeps the flag low
            if (step) begin
                flagn <= 1'b0;
            end else if (!flag_clr_n) begin
                flagn <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/mouse_bus_port.sv
/*
 * CPU read side of the trackball interface.
 * Chip select, byte select and axis select pick one byte of a count,
 * which is registered onto dout together with the switch and counter flags.
 */

`include "mouse_cfg.svh"

module mouse_bus_port
    import mouse_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  count_t    cnt_x,
    input  count_t    cnt_y,
    input  logic      flagn_x,
    input  logic      flagn_y,
    input  logic      rightn,                           // synchronized button levels
    input  logic      leftn,
    input  logic      middlen,
    input  logic      csn,                              // chip select, active low
    input  logic      uln,                              // high picks the upper byte
    input  logic      xn_y,                             // high picks the y axis
    output bus_byte_t dout,
    output logic      cfn,                              // low when either axis moved
    output logic      sfn                               // low when any button is pressed
);

    count_t    cnt_sel;
    bus_byte_t upper;
    bus_byte_t lower;

    assign cnt_sel = xn_y ? cnt_y : cnt_x;

    // status bits above the top nibble of the count
    assign upper = {sfn, leftn, rightn, middlen, cnt_sel[`MOUSE_CNT_W-1:`MOUSE_BYTE_W]};
    assign lower = cnt_sel[`MOUSE_BYTE_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
            cfn  <= 1'b1;
            sfn  <= 1'b1;
        end else begin
            if (!csn) begin
                dout <= uln ? upper : lower;            // follows the selects every cycle while selected
            end
            sfn <= rightn & leftn & middlen;
            cfn <= flagn_x & flagn_y;
        end
    end

endmodule

//--- verilog/mouse_counter_top.sv
/*
 * Top level of the two-axis trackball interface.
 * Joins the input synchronizers, one counter per axis and the CPU read port.
 */

module mouse_counter_top
    import mouse_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  quad_t     x_in,
    input  quad_t     y_in,
    input  logic      rightn,
    input  logic      leftn,
    input  logic      middlen,
    input  logic      x_rstn,
    input  logic      y_rstn,
    input  logic      csn,
    input  logic      uln,
    input  logic      xn_y,
    output bus_byte_t dout,
    output logic      cfn,
    output logic      sfn
);

    quad_t  x_q;
    quad_t  y_q;
    logic   right_q;
    logic   left_q;
    logic   middle_q;
    logic   x_clr_n;
    logic   y_clr_n;
    count_t cnt_x;
    count_t cnt_y;
    logic   flagn_x;
    logic   flagn_y;

    mouse_input_sync input_sync (
        .clk      (clk),
        .rst      (rst),
        .x_in     (x_in),
        .y_in     (y_in),
        .rightn   (rightn),
        .leftn    (leftn),
        .middlen  (middlen),
        .x_rstn   (x_rstn),
        .y_rstn   (y_rstn),
        .x_q      (x_q),
        .y_q      (y_q),
        .right_q  (right_q),
        .left_q   (left_q),
        .middle_q (middle_q),
        .x_clr_n  (x_clr_n),
        .y_clr_n  (y_clr_n)
    );

    // both axes see the raw chip select as their flag clear
    mouse_axis axis_x (
        .clk        (clk),
        .rst        (rst),
        .sig        (x_q),
        .clr_n      (x_clr_n),
        .flag_clr_n (csn),
        .flagn      (flagn_x),
        .count      (cnt_x)
    );

    mouse_axis axis_y (
        .clk        (clk),
        .rst        (rst),
        .sig        (y_q),
        .clr_n      (y_clr_n),
        .flag_clr_n (csn),
        .flagn      (flagn_y),
        .count      (cnt_y)
    );

    mouse_bus_port bus_port (
        .clk     (clk),
        .rst     (rst),
        .cnt_x   (cnt_x),
        .cnt_y   (cnt_y),
        .flagn_x (flagn_x),
        .flagn_y (flagn_y),
        .rightn  (right_q),
        .leftn   (left_q),
        .middlen (middle_q),
        .csn     (csn),
        .uln     (uln),
        .xn_y    (xn_y),
        .dout    (dout),
        .cfn     (cfn),
        .sfn     (sfn)
    );

endmodule

//--- tb/mouse_counter_checker.sv
/*
 * Reference model and comparator for the trackball interface testbench.
 * Watches the DUT pins, rebuilds counts and flags from the decoding rules
 * and compares dout, cfn and sfn on the cycle after each selected cycle.
 */

`include "mouse_cfg.svh"

module mouse_counter_checker
    import mouse_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  quad_t     x_in,
    input  quad_t     y_in,
    input  logic      rightn,
    input  logic      leftn,
    input  logic      middlen,
    input  logic      x_rstn,
    input  logic      y_rstn,
    input  logic      csn,
    input  logic      uln,
    input  logic      xn_y,
    input  bus_byte_t dout,
    input  logic      cfn,
    input  logic      sfn,
    output int        errors,
    output int        checks
);

    localparam int LAST = `MOUSE_SYNC_STAGES - 1;

    quad_t      x_pipe [`MOUSE_SYNC_STAGES];             // pin to clk domain delay of each pair
    quad_t      y_pipe [`MOUSE_SYNC_STAGES];
    logic [2:0] btn_pipe [`MOUSE_SYNC_STAGES];           // middle, left, right from msb down
    logic [1:0] clr_pipe [`MOUSE_SYNC_STAGES];           // y clear in bit 1, x clear in bit 0
    quad_t      m_prev [2];                              // index 0 is x and 1 is y
    logic [1:0] m_hist [2];
    logic       m_dir [2];
    logic       m_flagn [2];
    count_t     m_cnt [2];
    bus_byte_t  m_dout;
    logic       m_cfn;
    logic       m_sfn;
    logic       cs_seen;                                 // csn was low at the last rising edge

    always @(posedge clk or posedge rst) begin : model
        quad_t  sig;
        quad_t  chg;
        logic   moving;
        count_t sel;
        if (rst) begin
            for (int i = 0; i < `MOUSE_SYNC_STAGES; i++) begin
                x_pipe[i]   <= 2'b00;
                y_pipe[i]   <= 2'b00;
                btn_pipe[i] <= 3'b111;
                clr_pipe[i] <= 2'b11;
            end
            for (int a = 0; a < 2; a++) begin
                m_prev[a]  <= 2'b00;
                m_hist[a]  <= 2'b00;
                m_dir[a]   <= 1'b0;
                m_flagn[a] <= 1'b1;
                m_cnt[a]   <= '0;
            end
            m_dout  <= '0;
            m_cfn   <= 1'b1;
            m_sfn   <= 1'b1;
            cs_seen <= 1'b0;
        end else begin
            x_pipe[0]   <= x_in;
            y_pipe[0]   <= y_in;
            btn_pipe[0] <= {middlen, leftn, rightn};
            clr_pipe[0] <= {y_rstn, x_rstn};
            for (int i = 1; i < `MOUSE_SYNC_STAGES; i++) begin
                x_pipe[i]   <= x_pipe[i-1];
                y_pipe[i]   <= y_pipe[i-1];
                btn_pipe[i] <= btn_pipe[i-1];
                clr_pipe[i] <= clr_pipe[i-1];
            end
            for (int a = 0; a < 2; a++) begin
                sig    = (a == 0) ? x_pipe[LAST] : y_pipe[LAST];
                chg    = sig ^ m_prev[a];
                moving = (chg != 2'b00) && (m_hist[a][0] != m_hist[a][1]); // alternating channels
                if (!clr_pipe[LAST][a]) begin
                    m_prev[a]  <= sig;
                    m_hist[a]  <= 2'b00;
                    m_dir[a]   <= 1'b0;
                    m_flagn[a] <= 1'b1;
                    m_cnt[a]   <= '0;
                end else begin
                    m_prev[a] <= sig;
                    if (chg != 2'b00) begin
                        if (moving) begin
                            m_cnt[a] <= m_dir[a] ? m_cnt[a] - 1'b1 : m_cnt[a] + 1'b1;
                        end else begin
                            // relearn, down for A rising with B high or A falling with B low
                            m_dir[a] <= (sig[0] && !m_prev[a][0] && sig[1]) ||
                                        (!sig[0] && m_prev[a][0] && !sig[1]);
                        end
                        m_hist[a] <= {m_hist[a][0], chg[0]};
                    end
                    if (moving) begin
                        m_flagn[a] <= 1'b0;                  // motion beats a read in the same cycle
                    end else if (!csn) begin
                        m_flagn[a] <= 1'b1;
                    end
                end
            end
            sel = xn_y ? m_cnt[1] : m_cnt[0];
            if (!csn) begin
                m_dout <= uln ? {m_sfn, btn_pipe[LAST][1], btn_pipe[LAST][0],
                                 btn_pipe[LAST][2], sel[11:8]} : sel[7:0];
            end
            m_sfn   <= &btn_pipe[LAST];
            m_cfn   <= m_flagn[0] & m_flagn[1];
            cs_seen <= !csn;
        end
    end

    // outputs are settled at the falling edge, well away from the update
    initial begin
        errors = 0;
        checks = 0;
    end

    always @(negedge clk) begin
        if (!rst && cs_seen) begin
            checks = checks + 1;
            if (dout !== m_dout) begin
                errors = errors + 1;
                $display("mismatch at %0t: dout %h, expected %h", $time, dout, m_dout);
            end
            if (cfn !== m_cfn) begin
                errors = errors + 1;
                $display("mismatch at %0t: cfn %b, expected %b", $time, cfn, m_cfn);
            end
            if (sfn !== m_sfn) begin
                errors = errors + 1;
                $display("mismatch at %0t: sfn %b, expected %b", $time, sfn, m_sfn);
            end
        end
    end

endmodule

//--- tb/mouse_counter_tb.sv
/*
 * Testbench of the trackball interface.
 * Builds a table of moves, button levels, clears and reads, applies it on
 * falling edges and lets the checker compare every read.
 */

`include "mouse_cfg.svh"

module mouse_counter_tb
    import mouse_pkg::*;
;

    localparam int OP_XSTEP = 0;                         // val 1 steps forward and 0 steps back
    localparam int OP_YSTEP = 1;
    localparam int OP_BTN   = 2;                         // val holds {middlen, leftn, rightn}
    localparam int OP_XCLR  = 3;                         // rep is the low time in cycles
    localparam int OP_YCLR  = 4;
    localparam int OP_READ  = 5;                         // rep reads with the given selects

    logic      clk;
    logic      rst;
    quad_t     x_in;
    quad_t     y_in;
    logic      rightn;
    logic      leftn;
    logic      middlen;
    logic      x_rstn;
    logic      y_rstn;
    logic      csn;
    logic      uln;
    logic      xn_y;
    bus_byte_t dout;
    logic      cfn;
    logic      sfn;
    int        errors;
    int        checks;
    int        cycles;
    int        cycle_limit;
    int        x_phase;                                  // position in the gray sequence
    int        y_phase;
    int        op_q [$];
    int        val_q [$];
    int        rep_q [$];
    logic      uln_q [$];
    logic      xn_y_q [$];

    mouse_counter_top mouse_counter_top_i (
        .clk(clk), .rst(rst), .x_in(x_in), .y_in(y_in),
        .rightn(rightn), .leftn(leftn), .middlen(middlen),
        .x_rstn(x_rstn), .y_rstn(y_rstn), .csn(csn), .uln(uln), .xn_y(xn_y),
        .dout(dout), .cfn(cfn), .sfn(sfn)
    );

    mouse_counter_checker checker_i (
        .clk(clk), .rst(rst), .x_in(x_in), .y_in(y_in),
        .rightn(rightn), .leftn(leftn), .middlen(middlen),
        .x_rstn(x_rstn), .y_rstn(y_rstn), .csn(csn), .uln(uln), .xn_y(xn_y),
        .dout(dout), .cfn(cfn), .sfn(sfn), .errors(errors), .checks(checks)
    );

    always #4 clk = ~clk;

    // forward order 00, 01, 11, 10 lets phase A lead phase B
    function automatic quad_t gray_code(input int phase);
        case (phase & 3)
            0:       gray_code = 2'b00;
            1:       gray_code = 2'b01;
            2:       gray_code = 2'b11;
            default: gray_code = 2'b10;
        endcase
    endfunction

    task automatic add_row(input int op, input int val, input int rep, input logic u,
                           input logic y);
        op_q.push_back(op);
        val_q.push_back(val);
        rep_q.push_back(rep);
        uln_q.push_back(u);
        xn_y_q.push_back(y);
    endtask

    task automatic add_reads(input logic y);
        add_row(OP_READ, 0, 1, 1'b0, y);                 // lower byte then upper byte
        add_row(OP_READ, 0, 1, 1'b1, y);
    endtask

    task automatic apply_row(input int r);
        for (int n = 0; n < rep_q[r]; n++) begin
            if (op_q[r] == OP_XSTEP || op_q[r] == OP_YSTEP) begin
                if (op_q[r] == OP_XSTEP) begin
                    x_phase = x_phase + ((val_q[r] != 0) ? 1 : 3);
                    x_in    = gray_code(x_phase);
                end else begin
                    y_phase = y_phase + ((val_q[r] != 0) ? 1 : 3);
                    y_in    = gray_code(y_phase);
                end
                repeat (6) @(negedge clk);               // longer than the pin to count latency
            end else if (op_q[r] == OP_READ) begin
                csn  = 1'b0;
                uln  = uln_q[r];
                xn_y = xn_y_q[r];
                repeat (2) @(negedge clk);
                csn = 1'b1;
                repeat (2) @(negedge clk);
            end else if (op_q[r] == OP_BTN) begin
                {middlen, leftn, rightn} = val_q[r][2:0];
                repeat (6) @(negedge clk);
            end
        end
        if (op_q[r] == OP_XCLR || op_q[r] == OP_YCLR) begin
            if (op_q[r] == OP_XCLR) begin
                x_rstn = 1'b0;
            end else begin
                y_rstn = 1'b0;
            end
            repeat (rep_q[r]) @(negedge clk);
            x_rstn = 1'b1;
            y_rstn = 1'b1;
            repeat (6) @(negedge clk);                   // let the release pass the synchronizer
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the stimulus did not complete", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        x_in    = 2'b00;
        y_in    = 2'b00;
        rightn  = 1'b1;
        leftn   = 1'b1;
        middlen = 1'b1;
        x_rstn  = 1'b1;
        y_rstn  = 1'b1;
        csn     = 1'b1;
        uln     = 1'b0;
        xn_y    = 1'b0;
        cycles  = 0;
        x_phase = 0;
        y_phase = 0;
        void'($urandom(32'heed5_debb));
        add_reads(1'b0);                                 // reset values
        add_row(OP_XSTEP, 1, 10, 1'b0, 1'b0);
        add_reads(1'b0);
        add_reads(1'b1);                                 // y still 0 and cfn back high
        add_row(OP_XSTEP, 1, 300, 1'b0, 1'b0);           // carry into the high nibble
        add_reads(1'b0);
        add_row(OP_YSTEP, 0, 5, 1'b0, 1'b0);             // wraps below zero
        add_reads(1'b1);
        add_row(OP_YSTEP, 0, 4 + int'($urandom % 16), 1'b0, 1'b0);
        add_reads(1'b1);
        add_row(OP_YSTEP, 1, 3, 1'b0, 1'b0);             // reversal mid sequence
        add_row(OP_YSTEP, 0, 2, 1'b0, 1'b0);
        add_reads(1'b1);
        add_row(OP_XSTEP, 0, 2 + int'($urandom % 12), 1'b0, 1'b0);
        add_reads(1'b0);
        for (int b = 0; b < 8; b++) begin
            add_row(OP_BTN, b, 1, 1'b0, 1'b0);
            add_row(OP_READ, 0, 1, 1'b1, b[0]);
        end
        add_row(OP_BTN, 7, 1, 1'b0, 1'b0);
        add_row(OP_XCLR, 0, 3, 1'b0, 1'b0);
        add_reads(1'b0);
        add_reads(1'b1);
        add_row(OP_YCLR, 0, 3, 1'b0, 1'b0);
        add_reads(1'b1);
        cycle_limit = 5 + 50;
        foreach (op_q[r]) begin
            cycle_limit = cycle_limit + ((op_q[r] == OP_READ) ? 4 : 6) * rep_q[r] + 6;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (op_q[r]) begin
            apply_row(r);
        end
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
verilog/mouse_pkg.sv
verilog/mouse_input_sync.sv
verilog/mouse_axis.sv
verilog/mouse_bus_port.sv
verilog/mouse_counter_top.sv
tb/mouse_counter_checker.sv
tb/mouse_counter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the trackball interface testbench with Verilator and run it.
# Exits non-zero when the build, the run or the result fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module mouse_counter_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmouse_counter_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All checks passed"; then
    exit 0
else
    echo "pass message not found in the simulation output"
    exit 1
fi
